//--- hdl/mipsPkg.sv
`default_nettype none

package mipsPkg;

    localparam int wordW    = 32;
    localparam int regAddrW = 5;

    typedef logic [wordW-1:0]    word_t;
    typedef logic [regAddrW-1:0] regAddr_t;

    typedef enum logic [5:0] {
        opSpecial = 6'h00,
        opJ       = 6'h02,
        opBeq     = 6'h04,
        opBne     = 6'h05,
        opAddiu   = 6'h09,
        opAndi    = 6'h0c,
        opOri     = 6'h0d,
        opLui     = 6'h0f,
        opLw      = 6'h23,
        opSw      = 6'h2b
    } opcode_t;

    typedef enum logic [5:0] {
        fnAddu = 6'h21,
        fnSubu = 6'h23,
        fnAnd  = 6'h24,
        fnOr   = 6'h25,
        fnSlt  = 6'h2a
    } funct_t;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt,
        aluLui
    } aluOp_t;

    // where an execute operand comes from
    typedef enum logic [1:0] {
        fwdRf,
        fwdMem,
        fwdWb
    } fwdSel_t;

    typedef struct packed {
        opcode_t    opcode;
        regAddr_t   rs;
        regAddr_t   rt;
        regAddr_t   rd;
        logic [4:0] shamt;
        funct_t     funct;
    } rFields_t;

    typedef struct packed {
        opcode_t     opcode;
        regAddr_t    rs;
        regAddr_t    rt;
        logic [15:0] imm;
    } iFields_t;

    typedef union packed {
        rFields_t r;
        iFields_t i;
    } instr_t;

endpackage

`default_nettype wire

//--- hdl/fetchStage.sv
`default_nettype none

module fetchStage #(
    parameter mipsPkg::word_t resetPc = '0
) (
    input  logic            clk,
    input  logic            arstN,
    input  mipsPkg::word_t  instrF,
    input  logic            stallF,
    input  logic            stallD,
    input  logic            flushD,
    input  logic            jumpD,
    input  mipsPkg::word_t  jumpTargetD,
    input  logic            branchTakenE,
    input  mipsPkg::word_t  branchTargetE,
    output mipsPkg::word_t  pcF,
    output logic            instEnF,
    output mipsPkg::word_t  pcD,
    output mipsPkg::instr_t instrD
);

    mipsPkg::word_t nextPc;

    // older branch in execute wins over a jump in decode
    assign nextPc = branchTakenE ? branchTargetE :
                    jumpD        ? jumpTargetD   : pcF + 32'd4;

    assign instEnF = arstN;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pcF    <= resetPc;
            instrD <= '0;  // nop
        end else begin
            if (!stallF) begin
                pcF <= nextPc;
            end
            if (flushD) begin
                instrD <= '0;
            end else if (!stallD) begin
                instrD <= instrF;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stallD) begin
            pcD <= pcF;
        end
    end

    pcAligned: assert property (@(posedge clk) disable iff (!arstN) pcF[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- hdl/decodeStage.sv
`default_nettype none

module decodeStage (
    input  logic              clk,
    input  logic              arstN,
    input  mipsPkg::word_t    pcD,
    input  mipsPkg::instr_t   instrD,
    input  logic              stallE,
    input  logic              flushE,
    input  logic              wbWen,
    input  mipsPkg::regAddr_t wbAddr,
    input  mipsPkg::word_t    wbData,
    output logic              jumpD,
    output mipsPkg::word_t    jumpTargetD,
    output mipsPkg::regAddr_t rsD,
    output mipsPkg::regAddr_t rtD,
    output mipsPkg::word_t    pcE,
    output mipsPkg::regAddr_t rsE,
    output mipsPkg::regAddr_t rtE,
    output mipsPkg::regAddr_t dstE,
    output mipsPkg::word_t    rsValE,
    output mipsPkg::word_t    rtValE,
    output mipsPkg::word_t    immE,
    output mipsPkg::aluOp_t   aluOpE,
    output logic              aluImmE,
    output logic              branchE,
    output logic              branchNeE,
    output logic              memReadE,
    output logic              memWriteE,
    output logic              regWriteE
);

    mipsPkg::word_t    regs [32];
    mipsPkg::word_t    immD;
    mipsPkg::word_t    pcPlus4D;
    mipsPkg::regAddr_t dstD;
    mipsPkg::aluOp_t   aluOpD;
    logic aluImmD, zeroExtD, branchD, branchNeD, memReadD, memWriteD, writesD;

    function automatic mipsPkg::word_t readReg(mipsPkg::regAddr_t addr);
        if (addr == '0) return '0;
        if (wbWen && wbAddr == addr) return wbData;  // write-before-read
        return regs[addr];
    endfunction

    assign rsD = instrD.r.rs;
    assign rtD = instrD.i.rt;

    always_comb begin
        aluOpD    = mipsPkg::aluAdd;
        aluImmD   = 1'b1;
        zeroExtD  = 1'b0;
        branchD   = 1'b0;
        branchNeD = 1'b0;
        memReadD  = 1'b0;
        memWriteD = 1'b0;
        writesD   = 1'b0;
        jumpD     = 1'b0;
        dstD      = instrD.i.rt;
        case (instrD.r.opcode)
            mipsPkg::opSpecial: begin
                aluImmD = 1'b0;
                dstD    = instrD.r.rd;
                writesD = 1'b1;
                case (instrD.r.funct)
                    mipsPkg::fnAddu: aluOpD = mipsPkg::aluAdd;
                    mipsPkg::fnSubu: aluOpD = mipsPkg::aluSub;
                    mipsPkg::fnAnd:  aluOpD = mipsPkg::aluAnd;
                    mipsPkg::fnOr:   aluOpD = mipsPkg::aluOr;
                    mipsPkg::fnSlt:  aluOpD = mipsPkg::aluSlt;
                    default:         writesD = 1'b0;  // nop and anything else
                endcase
            end
            mipsPkg::opJ:     jumpD = 1'b1;
            mipsPkg::opBeq:   branchD = 1'b1;
            mipsPkg::opBne: begin
                branchD   = 1'b1;
                branchNeD = 1'b1;
            end
            mipsPkg::opAddiu: writesD = 1'b1;
            mipsPkg::opAndi: begin
                aluOpD   = mipsPkg::aluAnd;
                zeroExtD = 1'b1;
                writesD  = 1'b1;
            end
            mipsPkg::opOri: begin
                aluOpD   = mipsPkg::aluOr;
                zeroExtD = 1'b1;
                writesD  = 1'b1;
            end
            mipsPkg::opLui: begin
                aluOpD  = mipsPkg::aluLui;
                writesD = 1'b1;
            end
            mipsPkg::opLw: begin
                memReadD = 1'b1;
                writesD  = 1'b1;
            end
            mipsPkg::opSw:    memWriteD = 1'b1;
            default: ;
        endcase
    end

    assign immD = zeroExtD ? {16'h0000, instrD.i.imm} : {{16{instrD.i.imm[15]}}, instrD.i.imm};
    assign pcPlus4D    = pcD + 32'd4;
    assign jumpTargetD = {pcPlus4D[31:28], instrD.i.rs, instrD.i.rt, instrD.i.imm, 2'b00};

    always_ff @(posedge clk) begin
        if (wbWen && wbAddr != '0) begin
            regs[wbAddr] <= wbData;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rsE       <= '0;
            rtE       <= '0;
            dstE      <= '0;
            branchE   <= 1'b0;
            branchNeE <= 1'b0;
            memReadE  <= 1'b0;
            memWriteE <= 1'b0;
            regWriteE <= 1'b0;
        end else if (flushE || !stallE) begin
            rsE       <= flushE ? '0 : rsD;  // bubble reads r0
            rtE       <= flushE ? '0 : rtD;
            dstE      <= flushE ? '0 : dstD;
            branchE   <= branchD && !flushE;
            branchNeE <= branchNeD && !flushE;
            memReadE  <= memReadD && !flushE;
            memWriteE <= memWriteD && !flushE;
            regWriteE <= writesD && dstD != '0 && !flushE;
        end
    end

    always_ff @(posedge clk) begin
        if (!stallE) begin
            pcE     <= pcD;
            rsValE  <= readReg(rsD);
            rtValE  <= readReg(rtD);
            immE    <= immD;
            aluOpE  <= aluOpD;
            aluImmE <= aluImmD;
        end
    end

    // a loaded register never follows its load straight into execute
    loadUseHeld: assert property (@(posedge clk) disable iff (!arstN)
        memReadE && regWriteE && !stallE && !flushE |-> dstE != rsD && dstE != rtD);

endmodule

`default_nettype wire

//--- hdl/executeStage.sv
`default_nettype none

module executeStage (
    input  logic              clk,
    input  logic              arstN,
    input  mipsPkg::word_t    pcE,
    input  mipsPkg::regAddr_t dstE,
    input  mipsPkg::word_t    rsValE,
    input  mipsPkg::word_t    rtValE,
    input  mipsPkg::word_t    immE,
    input  mipsPkg::aluOp_t   aluOpE,
    input  logic              aluImmE,
    input  logic              branchE,
    input  logic              branchNeE,
    input  logic              memReadE,
    input  logic              memWriteE,
    input  logic              regWriteE,
    input  mipsPkg::fwdSel_t  fwdA,
    input  mipsPkg::fwdSel_t  fwdB,
    input  mipsPkg::word_t    memFwdData,
    input  mipsPkg::word_t    wbFwdData,
    input  logic              stallM,
    output logic              branchTakenE,
    output mipsPkg::word_t    branchTargetE,
    output mipsPkg::word_t    aluOutM,
    output mipsPkg::word_t    storeDataM,
    output mipsPkg::regAddr_t dstM,
    output logic              memReadM,
    output logic              memWriteM,
    output logic              regWriteM,
    output mipsPkg::word_t    pcM
);

    mipsPkg::word_t srcA, rtFwd, srcB, aluOut;

    function automatic mipsPkg::word_t pickOperand(mipsPkg::fwdSel_t sel, mipsPkg::word_t regVal);
        case (sel)
            mipsPkg::fwdMem: return memFwdData;
            mipsPkg::fwdWb:  return wbFwdData;
            default:         return regVal;
        endcase
    endfunction

    always_comb begin
        srcA  = pickOperand(fwdA, rsValE);
        rtFwd = pickOperand(fwdB, rtValE);  // also the store data
    end

    assign srcB = aluImmE ? immE : rtFwd;

    always_comb begin
        case (aluOpE)
            mipsPkg::aluAdd: aluOut = srcA + srcB;
            mipsPkg::aluSub: aluOut = srcA - srcB;
            mipsPkg::aluAnd: aluOut = srcA & srcB;
            mipsPkg::aluOr:  aluOut = srcA | srcB;
            mipsPkg::aluSlt: aluOut = {31'b0, $signed(srcA) < $signed(srcB)};
            mipsPkg::aluLui: aluOut = {srcB[15:0], 16'h0000};
            default:         aluOut = '0;
        endcase
    end

    assign branchTakenE  = branchE && ((srcA == rtFwd) != branchNeE);
    assign branchTargetE = pcE + 32'd4 + {immE[29:0], 2'b00};

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            dstM      <= '0;
            memReadM  <= 1'b0;
            memWriteM <= 1'b0;
            regWriteM <= 1'b0;
        end else if (!stallM) begin
            dstM      <= dstE;
            memReadM  <= memReadE;
            memWriteM <= memWriteE;
            regWriteM <= regWriteE;
        end
    end

    always_ff @(posedge clk) begin
        if (!stallM) begin
            aluOutM    <= aluOut;
            storeDataM <= rtFwd;
            pcM        <= pcE;
        end
    end

endmodule

`default_nettype wire

//--- hdl/memWriteback.sv
`default_nettype none

module memWriteback (
    input  logic              clk,
    input  logic              arstN,
    input  mipsPkg::word_t    aluOutM,
    input  mipsPkg::word_t    storeDataM,
    input  mipsPkg::regAddr_t dstM,
    input  logic              memReadM,
    input  logic              memWriteM,
    input  logic              regWriteM,
    input  mipsPkg::word_t    pcM,
    input  mipsPkg::word_t    memRdata,
    input  logic              dataStall,
    output logic              memEn,
    output logic              memWrite,
    output mipsPkg::word_t    memAddr,
    output mipsPkg::word_t    memWdata,
    output mipsPkg::word_t    memFwdData,
    output logic              wbWen,
    output mipsPkg::regAddr_t wbAddr,
    output mipsPkg::word_t    wbData,
    output mipsPkg::word_t    debugWbPc,
    output logic              debugWbRfWen,
    output mipsPkg::regAddr_t debugWbRfWnum,
    output mipsPkg::word_t    debugWbRfWdata
);

    logic freeze, regWriteW;

    assign memEn      = memReadM || memWriteM;
    assign memWrite   = memWriteM;
    assign memAddr    = aluOutM;
    assign memWdata   = storeDataM;
    assign memFwdData = aluOutM;  // loads never forward from here
    assign freeze     = memEn && dataStall;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            regWriteW <= 1'b0;
        end else if (!freeze) begin
            regWriteW <= regWriteM;
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            wbAddr    <= dstM;
            wbData    <= memReadM ? memRdata : aluOutM;
            debugWbPc <= pcM;
        end
    end

    // held entry retires once, after the freeze lifts
    assign wbWen          = regWriteW && !freeze;
    assign debugWbRfWen   = wbWen;
    assign debugWbRfWnum  = wbAddr;
    assign debugWbRfWdata = wbData;

    addrAligned: assert property (@(posedge clk) disable iff (!arstN)
        memEn |-> memAddr[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- hdl/hazardUnit.sv
`default_nettype none

module hazardUnit (
    input  logic              clk,
    input  logic              arstN,
    input  mipsPkg::regAddr_t rsD,
    input  mipsPkg::regAddr_t rtD,
    input  mipsPkg::regAddr_t rsE,
    input  mipsPkg::regAddr_t rtE,
    input  logic              memReadE,
    input  mipsPkg::regAddr_t dstE,
    input  logic              regWriteE,
    input  mipsPkg::regAddr_t dstM,
    input  logic              regWriteM,
    input  mipsPkg::regAddr_t wbAddr,
    input  logic              wbWen,
    input  logic              jumpD,
    input  logic              branchTakenE,
    input  logic              memEn,
    input  logic              dataStall,
    output mipsPkg::fwdSel_t  fwdA,
    output mipsPkg::fwdSel_t  fwdB,
    output logic              stallF,
    output logic              stallD,
    output logic              stallE,
    output logic              stallM,
    output logic              flushD,
    output logic              flushE
);

    logic freeze, loadUse;

    function automatic mipsPkg::fwdSel_t pickSource(mipsPkg::regAddr_t src);
        if (src == '0) return mipsPkg::fwdRf;
        if (regWriteM && dstM == src) return mipsPkg::fwdMem;  // youngest first
        if (wbWen && wbAddr == src) return mipsPkg::fwdWb;
        return mipsPkg::fwdRf;
    endfunction

    always_comb begin
        fwdA = pickSource(rsE);
        fwdB = pickSource(rtE);
    end

    assign freeze  = memEn && dataStall;
    assign loadUse = memReadE && regWriteE && (dstE == rsD || dstE == rtD);

    assign stallF = freeze || loadUse;
    assign stallD = freeze || loadUse;
    assign stallE = freeze;
    assign stallM = freeze;

    // redirects wait out a freeze
    assign flushD = !stallD && (jumpD || branchTakenE);
    assign flushE = !freeze && (loadUse || branchTakenE);

    // a taken branch leaves a bubble behind it in execute
    squashClearsE: assert property (@(posedge clk) disable iff (!arstN)
        branchTakenE && !freeze |=> !branchTakenE);

endmodule

`default_nettype wire

//--- hdl/mipsCore.sv
`default_nettype none

module mipsCore #(
    parameter mipsPkg::word_t resetPc = '0
) (
    input  logic              clk,
    input  logic              arstN,
    input  mipsPkg::word_t    instrF,
    input  mipsPkg::word_t    memRdata,
    input  logic              dataStall,
    output mipsPkg::word_t    pcF,
    output logic              instEnF,
    output logic              memEn,
    output logic              memWrite,
    output mipsPkg::word_t    memAddr,
    output mipsPkg::word_t    memWdata,
    output mipsPkg::word_t    debugWbPc,
    output logic              debugWbRfWen,
    output mipsPkg::regAddr_t debugWbRfWnum,
    output mipsPkg::word_t    debugWbRfWdata
);

    // decode
    mipsPkg::word_t    pcD, jumpTargetD;
    mipsPkg::instr_t   instrD;
    mipsPkg::regAddr_t rsD, rtD;
    logic              jumpD;
    // execute
    mipsPkg::word_t    pcE, rsValE, rtValE, immE, branchTargetE;
    mipsPkg::regAddr_t rsE, rtE, dstE;
    mipsPkg::aluOp_t   aluOpE;
    logic aluImmE, branchE, branchNeE, memReadE, memWriteE, regWriteE, branchTakenE;
    // memory and writeback
    mipsPkg::word_t    aluOutM, storeDataM, pcM, memFwdData, wbData;
    mipsPkg::regAddr_t dstM, wbAddr;
    logic              memReadM, memWriteM, regWriteM, wbWen;
    // hazard control
    mipsPkg::fwdSel_t  fwdA, fwdB;
    logic stallF, stallD, stallE, stallM, flushD, flushE;

    fetchStage #(.resetPc(resetPc)) fetch (
        .clk, .arstN, .instrF, .stallF, .stallD, .flushD,
        .jumpD, .jumpTargetD, .branchTakenE, .branchTargetE,
        .pcF, .instEnF, .pcD, .instrD
    );

    decodeStage decode (
        .clk, .arstN, .pcD, .instrD, .stallE, .flushE, .wbWen, .wbAddr, .wbData,
        .jumpD, .jumpTargetD, .rsD, .rtD,
        .pcE, .rsE, .rtE, .dstE, .rsValE, .rtValE, .immE, .aluOpE, .aluImmE,
        .branchE, .branchNeE, .memReadE, .memWriteE, .regWriteE
    );

    executeStage execute (
        .clk, .arstN, .pcE, .dstE, .rsValE, .rtValE, .immE, .aluOpE, .aluImmE,
        .branchE, .branchNeE, .memReadE, .memWriteE, .regWriteE,
        .fwdA, .fwdB, .memFwdData, .wbFwdData(wbData), .stallM,
        .branchTakenE, .branchTargetE,
        .aluOutM, .storeDataM, .dstM, .memReadM, .memWriteM, .regWriteM, .pcM
    );

    memWriteback memWb (
        .clk, .arstN, .aluOutM, .storeDataM, .dstM, .memReadM, .memWriteM,
        .regWriteM, .pcM, .memRdata, .dataStall,
        .memEn, .memWrite, .memAddr, .memWdata, .memFwdData,
        .wbWen, .wbAddr, .wbData,
        .debugWbPc, .debugWbRfWen, .debugWbRfWnum, .debugWbRfWdata
    );

    hazardUnit hazard (
        .clk, .arstN, .rsD, .rtD, .rsE, .rtE, .memReadE, .dstE, .regWriteE,
        .dstM, .regWriteM, .wbAddr, .wbWen, .jumpD, .branchTakenE, .memEn, .dataStall,
        .fwdA, .fwdB, .stallF, .stallD, .stallE, .stallM, .flushD, .flushE
    );

endmodule

`default_nettype wire

//--- bench/isaModel.svh
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

localparam int progLen = 64;
localparam int memWords = 64;
localparam logic [31:0] lfsrSeed = 32'h3641b3b7;

logic [31:0] lfsr = lfsrSeed;
mipsPkg::instr_t progMem [progLen];
mipsPkg::word_t modelRegs [32];
mipsPkg::word_t modelMem [memWords];

// expected retirement trace and store trace
mipsPkg::word_t expPcQ [$];
mipsPkg::regAddr_t expNumQ [$];
mipsPkg::word_t expValQ [$];
mipsPkg::word_t expAddrQ [$];
mipsPkg::word_t expDataQ [$];

int regSeen = 0;
int storeSeen = 0;
int errorCount = 0;

// one Galois step per bit taken from the lsb
function automatic logic [31:0] takeBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
        v = {v[30:0], lfsr[0]};
        lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h80200003 : 32'h0);
    end
    return v;
endfunction

function automatic mipsPkg::regAddr_t pickReg();
    logic [31:0] v;
    v = takeBits(3);
    return {2'b00, v[2:0]};  // only r0..r7
endfunction

function automatic logic [15:0] randImm();
    logic [31:0] v;
    v = takeBits(16);
    return v[15:0];
endfunction

function automatic mipsPkg::word_t memFill(input logic [5:0] idx);
    return (32'h9e3779b9 * {26'd0, idx}) ^ 32'h5bd1e995;
endfunction

function automatic mipsPkg::instr_t rType(input mipsPkg::funct_t fn, input mipsPkg::regAddr_t rd,
                                          input mipsPkg::regAddr_t rs,
                                          input mipsPkg::regAddr_t rt);
    mipsPkg::instr_t w;
    w = '0;
    w.r.opcode = mipsPkg::opSpecial;
    w.r.rs = rs;
    w.r.rt = rt;
    w.r.rd = rd;
    w.r.funct = fn;
    return w;
endfunction

function automatic mipsPkg::instr_t iType(input mipsPkg::opcode_t op, input mipsPkg::regAddr_t rs,
                                          input mipsPkg::regAddr_t rt, input logic [15:0] imm);
    mipsPkg::instr_t w;
    w.i.opcode = op;
    w.i.rs = rs;
    w.i.rt = rt;
    w.i.imm = imm;
    return w;
endfunction

function automatic mipsPkg::instr_t jType(input logic [25:0] index);
    mipsPkg::instr_t w;
    w.i.opcode = mipsPkg::opJ;
    {w.i.rs, w.i.rt, w.i.imm} = index;
    return w;
endfunction

task automatic putInstr(input int idx, input mipsPkg::instr_t w);
    progMem[idx[5:0]] = w;
endtask

task automatic buildProgram();
    mipsPkg::regAddr_t rd, rs, rt;
    logic [15:0] imm;
    logic [31:0] bits;
    int kind, hop, target;
    for (int r = 1; r < 8; r++) begin
        imm = randImm();
        putInstr(r - 1, iType(mipsPkg::opAddiu, 5'd0, r[4:0], imm));
    end
    for (int i = 7; i < progLen - 1; i++) begin
        bits = takeBits(4);
        kind = bits;
        rd = pickReg();
        rs = pickReg();
        rt = pickReg();
        imm = randImm();
        bits = takeBits(2);
        target = i + 1 + bits;  // forward only
        if (target > progLen - 1) begin
            target = progLen - 1;
        end
        hop = target - i - 1;
        case (kind)
            0: putInstr(i, rType(mipsPkg::fnAddu, rd, rs, rt));
            1: putInstr(i, rType(mipsPkg::fnSubu, rd, rs, rt));
            2: putInstr(i, rType(mipsPkg::fnAnd, rd, rs, rt));
            3: putInstr(i, rType(mipsPkg::fnOr, rd, rs, rt));
            4: putInstr(i, rType(mipsPkg::fnSlt, rd, rs, rt));
            5: putInstr(i, iType(mipsPkg::opAddiu, rs, rt, imm));
            6: putInstr(i, iType(mipsPkg::opAndi, rs, rt, imm));
            7: putInstr(i, iType(mipsPkg::opOri, rs, rt, imm));
            8: putInstr(i, iType(mipsPkg::opLui, rs, rt, imm));
            9, 10: putInstr(i, iType(mipsPkg::opLw, 5'd0, rt, {8'd0, imm[5:0], 2'b00}));
            11, 12: putInstr(i, iType(mipsPkg::opSw, 5'd0, rt, {8'd0, imm[5:0], 2'b00}));
            13: putInstr(i, iType(mipsPkg::opBeq, rs, rt, hop[15:0]));
            14: putInstr(i, iType(mipsPkg::opBne, rs, rt, hop[15:0]));
            default: putInstr(i, jType(target[25:0]));
        endcase
    end
    target = progLen - 1;
    putInstr(target, jType(target[25:0]));  // parks the core
endtask

// runs the program sequentially and fills the expected traces
task automatic runModel();
    mipsPkg::instr_t w;
    mipsPkg::word_t pc, nextPc, rsV, rtV, sImm, addr, res;
    mipsPkg::regAddr_t dst;
    logic writes, done;
    for (int r = 0; r < 32; r++) begin
        modelRegs[r[4:0]] = '0;
    end
    for (int a = 0; a < memWords; a++) begin
        modelMem[a[5:0]] = memFill(a[5:0]);
    end
    pc = '0;
    done = 1'b0;
    for (int n = 0; n < progLen && !done; n++) begin
        w = progMem[pc[7:2]];
        rsV = modelRegs[w.i.rs];
        rtV = modelRegs[w.i.rt];
        sImm = {{16{w.i.imm[15]}}, w.i.imm};
        addr = rsV + sImm;
        nextPc = pc + 32'd4;
        dst = w.i.rt;
        writes = 1'b1;
        res = '0;
        case (w.i.opcode)
            mipsPkg::opSpecial: begin
                dst = w.r.rd;
                case (w.r.funct)
                    mipsPkg::fnAddu: res = rsV + rtV;
                    mipsPkg::fnSubu: res = rsV - rtV;
                    mipsPkg::fnAnd:  res = rsV & rtV;
                    mipsPkg::fnOr:   res = rsV | rtV;
                    mipsPkg::fnSlt:  res = {31'd0, $signed(rsV) < $signed(rtV)};
                    default:         writes = 1'b0;
                endcase
            end
            mipsPkg::opAddiu: res = rsV + sImm;
            mipsPkg::opAndi:  res = rsV & {16'h0000, w.i.imm};
            mipsPkg::opOri:   res = rsV | {16'h0000, w.i.imm};
            mipsPkg::opLui:   res = {w.i.imm, 16'h0000};
            mipsPkg::opLw:    res = modelMem[addr[7:2]];
            mipsPkg::opSw: begin
                writes = 1'b0;
                modelMem[addr[7:2]] = rtV;
                expAddrQ.push_back(addr);
                expDataQ.push_back(rtV);
            end
            mipsPkg::opBeq, mipsPkg::opBne: begin
                writes = 1'b0;
                if ((rsV == rtV) == (w.i.opcode == mipsPkg::opBeq)) begin
                    nextPc = nextPc + {sImm[29:0], 2'b00};
                end
            end
            mipsPkg::opJ: begin
                writes = 1'b0;
                nextPc = {nextPc[31:28], w.i.rs, w.i.rt, w.i.imm, 2'b00};
                done = nextPc == pc;
            end
            default: writes = 1'b0;
        endcase
        if (writes && dst != '0) begin
            modelRegs[dst] = res;
            expPcQ.push_back(pc);
            expNumQ.push_back(dst);
            expValQ.push_back(res);
        end
        pc = nextPc;
    end
endtask

task automatic checkRegWrite(input mipsPkg::word_t pc, input mipsPkg::regAddr_t num,
                             input mipsPkg::word_t val);
    if (regSeen >= expPcQ.size()) begin
        errorCount++;
        $display("register write beyond the end of the expected trace at time %0t: pc %h r%0d",
                 $time, pc, num);
    end else if (pc !== expPcQ[regSeen] || num !== expNumQ[regSeen]
                 || val !== expValQ[regSeen]) begin
        errorCount++;
        $display("MISMATCH at time %0t: write got pc %h r%0d = %h, expected pc %h r%0d = %h",
                 $time, pc, num, val, expPcQ[regSeen], expNumQ[regSeen], expValQ[regSeen]);
    end
    regSeen++;
endtask

task automatic checkStore(input mipsPkg::word_t addr, input mipsPkg::word_t data);
    if (storeSeen >= expAddrQ.size()) begin
        errorCount++;
        $display("store beyond the end of the expected trace at time %0t: addr %h", $time, addr);
    end else if (addr !== expAddrQ[storeSeen] || data !== expDataQ[storeSeen]) begin
        errorCount++;
        $display("MISMATCH at time %0t: store got [%h] = %h, expected [%h] = %h",
                 $time, addr, data, expAddrQ[storeSeen], expDataQ[storeSeen]);
    end
    storeSeen++;
endtask

task automatic checkLevel(input string what, input logic got, input logic exp);
    if (got !== exp) begin
        errorCount++;
        $display("MISMATCH at time %0t: %s is %b, expected %b", $time, what, got, exp);
    end
endtask

`endif

//--- bench/coreTb.sv
`default_nettype none

module coreTb;

    localparam int clkPeriod = 8;
    localparam int resetCycles = 8;
    localparam int drainCycles = 30;  // lets late extra retirements show up

    logic              clk = 1'b0;
    logic              arstN = 1'b0;
    logic              dataStall = 1'b0;
    mipsPkg::word_t    instrF;
    mipsPkg::word_t    memRdata;
    mipsPkg::word_t    pcF;
    logic              instEnF;
    logic              memEn;
    logic              memWrite;
    mipsPkg::word_t    memAddr;
    mipsPkg::word_t    memWdata;
    mipsPkg::word_t    debugWbPc;
    logic              debugWbRfWen;
    mipsPkg::regAddr_t debugWbRfWnum;
    mipsPkg::word_t    debugWbRfWdata;

    `include "isaModel.svh"

    localparam mipsPkg::word_t progBytes = 4 * progLen;
    localparam int timeLimit = progLen * 20 * clkPeriod;

    mipsPkg::word_t dataMem [memWords];

    // both memories answer in the same cycle
    assign instrF   = (pcF < progBytes) ? mipsPkg::word_t'(progMem[pcF[7:2]]) : '0;
    assign memRdata = dataMem[memAddr[7:2]];

    mipsCore #(.resetPc('0)) UUT (
        .clk, .arstN, .instrF, .memRdata, .dataStall,
        .pcF, .instEnF, .memEn, .memWrite, .memAddr, .memWdata,
        .debugWbPc, .debugWbRfWen, .debugWbRfWnum, .debugWbRfWdata
    );

    initial begin
        forever #(clkPeriod / 2) clk = ~clk;
    end

    initial begin
        #(timeLimit);
        $display("timeout: the core did not retire the whole program within %0d time units",
                 timeLimit);
        $display("Test failed");
        $finish;
    end

    function automatic logic drawStall();
        logic [31:0] v;
        v = takeBits(2);
        return v[1:0] == 2'b00;  // about one in four
    endfunction

    always @(negedge clk) begin
        if (arstN && memEn) begin
            dataStall = drawStall();
        end else begin
            dataStall = 1'b0;
        end
    end

    // inputs were set at the last falling edge, so everything here is settled
    always @(posedge clk) begin
        if (arstN) begin
            checkLevel("instEnF", instEnF, 1'b1);
            if (debugWbRfWen) begin
                if (memEn && dataStall) begin
                    errorCount++;
                    $display("register write retired while the pipe was frozen at time %0t",
                             $time);
                end
                checkRegWrite(debugWbPc, debugWbRfWnum, debugWbRfWdata);
            end
            if (memEn && memWrite && !dataStall) begin
                checkStore(memAddr, memWdata);
                dataMem[memAddr[7:2]] = memWdata;
            end
        end
    end

    initial begin
        for (int a = 0; a < memWords; a++) begin
            dataMem[a[5:0]] = memFill(a[5:0]);
        end
        buildProgram();
        runModel();
        repeat (resetCycles) @(negedge clk);
        checkLevel("instEnF in reset", instEnF, 1'b0);
        checkLevel("memEn in reset", memEn, 1'b0);
        checkLevel("memWrite in reset", memWrite, 1'b0);
        checkLevel("debugWbRfWen in reset", debugWbRfWen, 1'b0);
        arstN = 1'b1;
        while (regSeen < expPcQ.size() || storeSeen < expAddrQ.size()) begin
            @(negedge clk);
        end
        repeat (drainCycles) @(negedge clk);
        if (regSeen != expPcQ.size() || storeSeen != expAddrQ.size()) begin
            errorCount++;
            $display("retired register writes or stores differ from the model's counts");
        end
        $display("register writes %0d/%0d, stores %0d/%0d, errors %0d",
                 regSeen, expPcQ.size(), storeSeen, expAddrQ.size(), errorCount);
        if (errorCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+bench
hdl/mipsPkg.sv
hdl/fetchStage.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/memWriteback.sv
hdl/hazardUnit.sv
hdl/mipsCore.sv
bench/coreTb.sv

//--- run.sh
#!/usr/bin/env bash
# build the core testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module coreTb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/VcoreTb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Test completed successfully"; then
    exit 0
fi
exit 1
